/* vlog.f */
rtl/block_pkg.sv
rtl/fifo_buffer.sv
rtl/credit_counter.sv
rtl/whitening_stage.sv
rtl/block_whitener.sv
verif/clk_gen.sv
verif/block_whitener_sva.sv
verif/tb_block_whitener.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the block whitener testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_block_whitener -f vlog.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_block_whitener +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "PASS: all tests" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* verif/tb_block_whitener.sv */
`default_nettype none

module tb_block_whitener
	import block_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH = 8;
	localparam int OUT_CREDITS = 4;
	localparam int TOTAL_BLOCKS = 1 + 8 + 12 + 64;
	localparam int CYCLE_LIMIT = 40 * TOTAL_BLOCKS + 200;

	localparam block_t KEY_A = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
	localparam block_t KEY_B = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;

	// Gap is the number of idle cycles after the block.
	typedef struct packed
	{
		logic [7:0] gap;
		block_t data;
	} tx_item_t;

	logic clk;
	logic rst;
	logic in_valid;
	block_t in_block;
	logic in_credit;
	block_t key;
	logic out_valid;
	block_t out_block;
	logic out_credit;

	tx_item_t tx_q[$];
	block_t exp_q[$];
	logic [7:0] ret_gaps[$];

	int cycle = 0;
	int up_credits = FIFO_DEPTH;
	int in_credit_total = 0;
	int out_total = 0;
	int last_send_edge = 0;
	int last_out_cycle = 0;
	bit hold_credits = 1'b0;
	int error_count = 0;
	int checks_done = 0;
	int test_errors_start = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int seed = 32'h8647;
	string cur_test = "reset_state";

	clk_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(2)
	) u_clk_gen (
		.clk(clk),
		.rst(rst)
	);

	block_whitener #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) u_block_whitener (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_block(in_block),
		.in_credit(in_credit),
		.key(key),
		.out_valid(out_valid),
		.out_block(out_block),
		.out_credit(out_credit)
	);

	// Expected output.
	function automatic block_t whiten(input block_t data, input block_t round_key);
		return data ^ round_key;
	endfunction

	function automatic block_t random_block();
		logic [BLOCK_W-1:0] bits;
		int k;
		for (k = 0; k < BLOCK_W / 32; k++)
			bits[k*32 +: 32] = $random(seed);
		return block_t'(bits);
	endfunction

	function automatic logic [7:0] random_gap(input int max_gap);
		int unsigned r;
		r = $unsigned($random(seed));
		return 8'(r % (max_gap + 1));
	endfunction

	function automatic int sva_failures();
		return u_block_whitener.u_sva.full_write_fails + u_block_whitener.u_sva.credit_fails
			+ u_block_whitener.u_sva.flag_fails;
	endfunction

	task automatic check_block(input string name, input block_t expected, input block_t actual);
		checks_done++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s, expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		checks_done++;
		if (actual != expected)
		begin
			error_count++;
			$display("[ERROR] %s, expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks_done++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s, expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic queue_block(input block_t data, input logic [7:0] gap);
		tx_item_t item;
		item.gap = gap;
		item.data = data;
		tx_q.push_back(item);
	endtask

	task automatic wait_drain();
		while (tx_q.size() != 0 || exp_q.size() != 0)
			@(negedge clk);
		repeat (OUT_CREDITS + 4) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors_start = error_count;
	endtask

	task automatic finish_test();
		int errs;
		errs = error_count - test_errors_start;
		if (errs == 0)
		begin
			tests_passed++;
			$display("test %s passed", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errs);
		end
	endtask

	initial
	begin
		forever
		begin
			@(posedge clk);
			cycle = cycle + 1;
		end
	end

	initial
	begin
		wait (cycle >= CYCLE_LIMIT);
		$display("simulation timed out after %0d cycles", cycle);
		$display("FAIL: see errors above");
		$finish;
	end

	// Upstream model, holds one credit per free FIFO entry.
	initial
	begin
		int gap_left;
		tx_item_t item;
		gap_left = 0;
		in_valid = 1'b0;
		in_block = '0;
		forever
		begin
			@(negedge clk);
			in_valid = 1'b0;
			if (in_credit === 1'b1)
			begin
				up_credits++;
				in_credit_total++;
			end
			if (gap_left > 0)
				gap_left--;
			else if (tx_q.size() > 0 && up_credits > 0 && rst === 1'b0)
			begin
				item = tx_q.pop_front();
				in_valid = 1'b1;
				in_block = item.data;
				exp_q.push_back(whiten(item.data, key));
				up_credits--;
				last_send_edge = cycle + 1;
				gap_left = int'(item.gap);
			end
		end
	end

	// Downstream model.
	initial
	begin
		int owed;
		int wait_left;
		owed = 0;
		wait_left = 0;
		out_credit = 1'b0;
		forever
		begin
			@(negedge clk);
			out_credit = 1'b0;
			if (out_valid === 1'b1)
				owed++;
			if (wait_left > 0)
				wait_left--;
			else if (!hold_credits && owed > 0)
			begin
				out_credit = 1'b1;
				owed--;
				if (ret_gaps.size() > 0)
					wait_left = int'(ret_gaps.pop_front());
			end
		end
	end

	// Scoreboard.
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (out_valid === 1'b1)
			begin
				out_total++;
				last_out_cycle = cycle;
				if (exp_q.size() == 0)
				begin
					error_count++;
					$display("[ERROR] %s: out_valid with no block outstanding", cur_test);
				end
				else
					check_block(cur_test, exp_q.pop_front(), out_block);
			end
		end
	end

	initial
	begin
		int outs_before;
		int credits_before;
		int i;
		int half;
		block_t b;
		key = KEY_A;

		start_test("reset_state");
		@(posedge clk);
		@(negedge clk);
		check_flag("reset_state out_valid in reset", 1'b0, out_valid);
		check_flag("reset_state in_credit in reset", 1'b0, in_credit);
		while (rst)
			@(negedge clk);
		check_flag("reset_state out_valid after reset", 1'b0, out_valid);
		check_flag("reset_state in_credit after reset", 1'b0, in_credit);
		repeat (10) @(negedge clk);
		check_count("reset_state idle outputs", 0, out_total);
		finish_test();

		start_test("single_block");
		outs_before = out_total;
		credits_before = in_credit_total;
		queue_block(128'h00112233_44556677_8899aabb_ccddeeff, 8'd0);
		wait_drain();
		check_count("single_block outputs", 1, out_total - outs_before);
		check_count("single_block latency", 3, last_out_cycle - last_send_edge);
		check_count("single_block in_credit pulses", 1, in_credit_total - credits_before);
		finish_test();

		start_test("fifo_order");
		outs_before = out_total;
		credits_before = in_credit_total;
		for (i = 0; i < FIFO_DEPTH; i++)
		begin
			b.w3 = 32'h0123_4500 + word_t'(i);
			b.w2 = 32'h89ab_cd00 + word_t'(i);
			b.w1 = ~word_t'(i);
			b.w0 = word_t'(i * 32'h0101_0101);
			queue_block(b, 8'd0);
		end
		wait_drain();
		check_count("fifo_order outputs", FIFO_DEPTH, out_total - outs_before);
		check_count("fifo_order in_credit pulses", FIFO_DEPTH, in_credit_total - credits_before);
		finish_test();

		start_test("back_pressure");
		hold_credits = 1'b1;
		outs_before = out_total;
		credits_before = in_credit_total;
		for (i = 0; i < 12; i++)
			queue_block(random_block(), 8'd0);
		while (tx_q.size() != 0)
			@(negedge clk);
		repeat (20) @(negedge clk);
		check_count("back_pressure outputs while held", OUT_CREDITS, out_total - outs_before);
		check_count("back_pressure upstream credits", 0, up_credits);
		check_count("back_pressure in_credit while held", OUT_CREDITS,
			in_credit_total - credits_before);
		hold_credits = 1'b0;
		wait_drain();
		check_count("back_pressure outputs", 12, out_total - outs_before);
		check_count("back_pressure in_credit pulses", 12, in_credit_total - credits_before);
		finish_test();

		start_test("random_stream");
		outs_before = out_total;
		for (half = 0; half < 2; half++)
		begin
			// Key only changes with nothing in flight.
			key = (half == 0) ? KEY_A : KEY_B;
			for (i = 0; i < 32; i++)
			begin
				ret_gaps.push_back(random_gap(3));
				queue_block(random_block(), random_gap(3));
			end
			wait_drain();
		end
		check_count("random_stream outputs", 64, out_total - outs_before);
		check_count("random_stream assertion failures", 0, sva_failures());
		finish_test();

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks_done, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/block_whitener_sva.sv */
`default_nettype none

module block_whitener_sva
#(
	parameter int OUT_CREDITS = 4
)
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid,
	input logic out_credit,
	input logic fifo_empty,
	input logic fifo_full
);

	timeunit 1ns;
	timeprecision 1ps;

	int full_write_fails = 0;
	int credit_fails = 0;
	int flag_fails = 0;

	// Downstream credits not yet matched by an output beat.
	int credits_left;

	always_ff @(posedge clk)
	begin
		if (rst)
			credits_left <= OUT_CREDITS;
		else
			credits_left <= credits_left - int'(out_valid) + int'(out_credit);
	end

	// Upstream has no credit left once the buffer is full.
	no_write_when_full: assert property (
		@(posedge clk) disable iff (rst)
		fifo_full |-> !in_valid
	)
	else
	begin
		$error("in_valid asserted while the FIFO is full");
		full_write_fails++;
	end

	// Each output beat spends one credit that downstream still holds.
	beat_needs_credit: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> credits_left > 0
	)
	else
	begin
		$error("out_valid without an output credit");
		credit_fails++;
	end

	flags_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(fifo_empty && fifo_full)
	)
	else
	begin
		$error("FIFO empty and full both high");
		flag_fails++;
	end

endmodule

bind block_whitener block_whitener_sva #(
	.OUT_CREDITS(OUT_CREDITS)
) u_sva (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.out_credit(out_credit),
	.fifo_empty(fifo_empty),
	.fifo_full(fifo_full)
);

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen
#(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
)
(
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

	// Released on a falling edge.
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/block_whitener.sv */
`default_nettype none

module block_whitener
	import block_pkg::*;
#(
	parameter int FIFO_DEPTH = 8,
	parameter int OUT_CREDITS = 4
)
(
	input logic clk,
	input logic rst,

	// Upstream.
	input logic in_valid,
	input block_t in_block,
	output logic in_credit,

	// Held stable while blocks are in flight.
	input block_t key,

	// Downstream.
	output logic out_valid,
	output block_t out_block,
	input logic out_credit
);

	block_t fifo_data;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_read;

	// Upstream credits keep writes away from a full buffer.
	fifo_buffer #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo_buffer (
		.clk(clk),
		.rst(rst),
		.write(in_valid),
		.read(fifo_read),
		.data_in(in_block),
		.data_out(fifo_data),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	whitening_stage #(
		.OUT_CREDITS(OUT_CREDITS)
	) u_whitening_stage (
		.clk(clk),
		.rst(rst),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data),
		.fifo_read(fifo_read),
		.key(key),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_block(out_block)
	);

endmodule

`default_nettype wire

/* rtl/whitening_stage.sv */
`default_nettype none

module whitening_stage
	import block_pkg::*;
#(
	parameter int OUT_CREDITS = 4
)
(
	input logic clk,
	input logic rst,

	// FIFO side.
	input logic fifo_empty,
	input block_t fifo_data,
	output logic fifo_read,

	input block_t key,

	// Credits in both directions.
	input logic out_credit,
	output logic in_credit,

	// Downstream.
	output logic out_valid,
	output block_t out_block
);

	logic has_credit;

	// Read data is valid the cycle after a pop.
	logic pop_q;

	logic hold_valid;
	block_t hold_block;

	credit_counter #(
		.INIT(OUT_CREDITS)
	) u_credit_counter (
		.clk(clk),
		.rst(rst),
		.consume(fifo_read),
		.give_back(out_credit),
		.has_credit(has_credit)
	);

	// AddRoundKey step, one word at a time.
	function automatic block_t whiten_block(input block_t data, input block_t k);
		block_t r;
		r.w3 = data.w3 ^ k.w3;
		r.w2 = data.w2 ^ k.w2;
		r.w1 = data.w1 ^ k.w1;
		r.w0 = data.w0 ^ k.w0;
		return r;
	endfunction

	// Pop only with a block waiting and room downstream.
	assign fifo_read = !fifo_empty && has_credit;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pop_q <= 1'b0;
			in_credit <= 1'b0;
			hold_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			pop_q <= fifo_read;
			// Each freed FIFO entry goes back upstream.
			in_credit <= fifo_read;
			hold_valid <= pop_q;
			out_valid <= hold_valid;
		end
	end

	// Captured before the FIFO register is overwritten by the next pop.
	always_ff @(posedge clk)
	begin
		if (pop_q)
			hold_block <= fifo_data;
		if (hold_valid)
			out_block <= whiten_block(hold_block, key);
	end

endmodule

`default_nettype wire

/* rtl/credit_counter.sv */
`default_nettype none

module credit_counter
	import block_pkg::*;
#(
	parameter int INIT = 4
)
(
	input logic clk,
	input logic rst,

	input logic consume,
	input logic give_back,

	output logic has_credit
);

	localparam int CNT_W = count_width(INIT);

	generate
		if (INIT < 1)
		begin : g_init_check
			$error("credit_counter needs at least one credit.");
		end
	endgenerate

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	// Spend and return in one cycle cancel.
	always_comb
	begin
		case ({consume, give_back})
			2'b10: count_next = count - 1'b1;
			2'b01: count_next = count + 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			count <= CNT_W'(INIT);
		else
			count <= count_next;
	end

	assign has_credit = (count != '0);

endmodule

`default_nettype wire

/* rtl/fifo_buffer.sv */
`default_nettype none

module fifo_buffer
	import block_pkg::*;
#(
	parameter int DEPTH = 8
)
(
	input logic clk,
	input logic rst,

	input logic write,
	input logic read,
	input block_t data_in,

	output block_t data_out,
	output logic empty,
	output logic full
);

	localparam int PTR_W = index_width(DEPTH);
	localparam int CNT_W = count_width(DEPTH);

	generate
		if (DEPTH < 2)
		begin : g_depth_check
			$error("fifo_buffer needs at least two entries.");
		end
	endgenerate

	block_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] rd_ptr_next;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	logic do_write;
	logic do_read;

	// Wraps at DEPTH, so the depth need not be a power of two.
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// A write into a full buffer is dropped.
	always_comb
	begin
		do_write = write && !full;
		do_read = read && !empty;
	end

	always_comb
	begin
		wr_ptr_next = wr_ptr;
		rd_ptr_next = rd_ptr;
		if (do_write)
			wr_ptr_next = ptr_inc(wr_ptr);
		if (do_read)
			rd_ptr_next = ptr_inc(rd_ptr);
	end

	// Read and write together leave the count alone.
	always_comb
	begin
		case ({do_write, do_read})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			empty <= 1'b1;
			full <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr_next;
			rd_ptr <= rd_ptr_next;
			count <= count_next;
			// Flags follow the next count.
			empty <= (count_next == '0);
			full <= (count_next == CNT_W'(DEPTH));
		end
	end

	// Storage and the read register.
	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* rtl/block_pkg.sv */
`default_nettype none

package block_pkg;

	// One 32-bit word of a cipher block.
	typedef logic [31:0] word_t;

	// w3 is the most significant word.
	typedef struct packed
	{
		word_t w3;
		word_t w2;
		word_t w1;
		word_t w0;
	} block_t;

	localparam int BLOCK_W = $bits(block_t);

	// Smallest width that holds every value from 0 to max_count.
	function automatic int count_width(input int max_count);
		int w;
		w = 1;
		while ((1 << w) <= max_count)
		begin
			w = w + 1;
		end
		return w;
	endfunction

	// Index width for a buffer of the given depth.
	function automatic int index_width(input int depth);
		return count_width(depth - 1);
	endfunction

endpackage

`default_nettype wire
